//--- source/ntt_mem_pkg.sv
/*
  Memory map, widths and word formats of the coefficient memory.
  Words 0 to 63 hold coefficients, 64 to 123 are scratch and the top
  four words are the control, enable, constant and status registers.
  Coefficients and shares are assumed to be below q when loaded.
*/

package ntt_mem_pkg;

    // ========================================
    // Widths and sizes
    // ========================================
    localparam int MEM_ADDR_W  = 7;
    localparam int MEM_DEPTH   = 2 ** MEM_ADDR_W;
    localparam int COEFF_W     = 24;
    localparam int BUS_DATA_W  = 64;
    localparam int LANE_W      = 2 * COEFF_W;
    localparam int ROW_W       = 384;
    localparam int NUM_LANES   = ROW_W / LANE_W;
    // Plain rows only fill the low four lanes
    localparam int PLAIN_LANES = 4;
    localparam int ROW_ADDR_W  = 4;

    // ========================================
    // Register addresses
    // ========================================
    localparam logic [MEM_ADDR_W-1:0] CTRL_REG   = 7'd124;
    localparam logic [MEM_ADDR_W-1:0] ENABLE_REG = 7'd125;
    localparam logic [MEM_ADDR_W-1:0] CONST_REG  = 7'd126;
    localparam logic [MEM_ADDR_W-1:0] STATUS_REG = 7'd127;

    // One bus word seen either as a single coefficient or as two shares
    typedef union packed {
        struct packed {
            logic [BUS_DATA_W-COEFF_W-1:0]   zero;
            logic [COEFF_W-1:0]              coeff;
        } plain;
        struct packed {
            logic [BUS_DATA_W-2*COEFF_W-1:0] zero;
            logic [COEFF_W-1:0]              share1;
            logic [COEFF_W-1:0]              share0;
        } masked;
    } coeff_word_u;

    // A row is eight lanes, each lane holds share 1 above share 0
    typedef logic [NUM_LANES-1:0][LANE_W-1:0] ntt_row_t;

endpackage

//--- source/ntt_ctrl_pkg.sv
/*
  Control fields, modulus and run lengths of the constant-add engine.
  Only bit 0 of the control and enable words carries meaning.
  The constant register must hold a value below q.
*/

package ntt_ctrl_pkg;

    // Modulus used for every coefficient and share
    localparam int unsigned NTT_Q = 32'd8380417;

    // Control word bit that selects masked mode
    localparam int CTRL_MASKED_BIT = 0;

    // Enable word bit whose rising edge starts a run
    localparam int ENABLE_START_BIT = 0;

    // ========================================
    // Rows per run
    // ========================================
    // Plain mode packs four coefficient words per row
    localparam int ROWS_PLAIN = 16;

    // Masked mode packs eight coefficient words per row
    localparam int ROWS_MASKED = 8;

endpackage

//--- source/ntt_mem_if.sv
/*
  Row traffic between the engine and the coefficient memory.
  Read data returns one cycle after rd_en, writes land in the same cycle.
  There is no back-pressure on either direction.
*/

`timescale 1ns/100ps

interface ntt_mem_if
    import ntt_mem_pkg::*;
();

    // Read request and the returned row
    logic                  rd_en;
    logic [ROW_ADDR_W-1:0] rd_addr;
    ntt_row_t              rd_data;

    // Write request with its row
    logic                  wr_en;
    logic [ROW_ADDR_W-1:0] wr_addr;
    ntt_row_t              wr_data;

    // Packing selector for both directions
    logic                  masked;

    modport engine (
        output rd_en, rd_addr, wr_en, wr_addr, wr_data, masked,
        input  rd_data
    );

    modport memory (
        input  rd_en, rd_addr, wr_en, wr_addr, wr_data, masked,
        output rd_data
    );

endinterface

//--- source/ntt_special_mem.sv
/*
  Coefficient memory with a 64-bit bus port and a 384-bit row port.
  The row packing follows the masked level on the row interface only.
  When the bus and the engine hit the same word, the engine write wins.
  Bus writes to the status word are lost to the done copy.
*/

`timescale 1ns/100ps

module ntt_special_mem
    import ntt_mem_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset_n,
    input  logic                  zeroize,

    // Bus side
    input  logic                  bus_en,
    input  logic                  bus_we,
    input  logic [MEM_ADDR_W-1:0] bus_addr,
    input  logic [BUS_DATA_W-1:0] bus_wdata,
    output logic [BUS_DATA_W-1:0] bus_rdata,

    // Engine side
    ntt_mem_if.memory             mem,
    input  logic                  done,
    output logic [BUS_DATA_W-1:0] ctrl_word,
    output logic [BUS_DATA_W-1:0] enable_word,
    output logic [BUS_DATA_W-1:0] const_word
);

    logic [BUS_DATA_W-1:0] words [MEM_DEPTH];

    // Row gathered from the array before the read register
    ntt_row_t              row_gather;
    ntt_row_t              row_q;

    // Row split into bus words before the write
    coeff_word_u           wr_words [NUM_LANES];

    // Register words leave without a clock stage
    assign ctrl_word   = words[CTRL_REG];
    assign enable_word = words[ENABLE_REG];
    assign const_word  = words[CONST_REG];

    assign mem.rd_data = row_q;

    // ========================================
    // Row packing
    // ========================================
    always_comb begin
        coeff_word_u rd_word;
        row_gather = '0;
        rd_word    = '0;
        for (int i = 0; i < NUM_LANES; i++) begin
            if (mem.masked) begin
                // Masked row r covers words 8r to 8r+7
                rd_word = coeff_word_u'(words[{mem.rd_addr, 3'(i)}]);
                row_gather[i] = {rd_word.masked.share1, rd_word.masked.share0};
            end else if (i < PLAIN_LANES) begin
                // Plain row r covers words 4r to 4r+3
                rd_word = coeff_word_u'(words[{1'b0, mem.rd_addr, 2'(i)}]);
                row_gather[i] = LANE_W'(rd_word.plain.coeff);
            end
        end
    end

    // Each lane goes back to one word, upper bits forced to zero
    always_comb begin
        for (int i = 0; i < NUM_LANES; i++) begin
            wr_words[i] = '0;
            if (mem.masked) begin
                wr_words[i].masked.share1 = mem.wr_data[i][LANE_W-1:COEFF_W];
                wr_words[i].masked.share0 = mem.wr_data[i][COEFF_W-1:0];
            end else begin
                wr_words[i].plain.coeff = mem.wr_data[i][COEFF_W-1:0];
            end
        end
    end

    // ========================================
    // Registered reads
    // ========================================
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            bus_rdata <= '0;
            row_q     <= '0;
        end else if (zeroize) begin
            bus_rdata <= '0;
            row_q     <= '0;
        end else begin
            // An idle bus cycle returns zero on the next cycle
            bus_rdata <= bus_en ? words[bus_addr] : '0;
            if (mem.rd_en) begin
                row_q <= row_gather;
            end
        end
    end

    // ========================================
    // Writes
    // ========================================
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            for (int i = 0; i < MEM_DEPTH; i++) begin
                words[i] <= '0;
            end
        end else if (zeroize) begin
            for (int i = 0; i < MEM_DEPTH; i++) begin
                words[i] <= '0;
            end
        end else begin
            if (bus_we) begin
                words[bus_addr] <= bus_wdata;
            end
            // Later assignment takes priority over the bus write
            if (mem.wr_en) begin
                for (int i = 0; i < NUM_LANES; i++) begin
                    if (mem.masked) begin
                        words[{mem.wr_addr, 3'(i)}] <= wr_words[i];
                    end else if (i < PLAIN_LANES) begin
                        words[{1'b0, mem.wr_addr, 2'(i)}] <= wr_words[i];
                    end
                end
            end
            // Status mirrors the engine done level every cycle
            words[STATUS_REG] <= {{(BUS_DATA_W-1){1'b0}}, done};
        end
    end

endmodule

//--- source/ntt_const_adder.sv
/*
  Engine that adds the constant to every coefficient modulo q.
  In masked mode only share 0 is shifted, share 1 passes unchanged.
  Inputs and the constant are assumed below q, nothing checks this.
  A start edge that arrives during a run is ignored.
*/

`timescale 1ns/100ps

module ntt_const_adder
    import ntt_mem_pkg::*;
    import ntt_ctrl_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset_n,
    input  logic                  zeroize,
    ntt_mem_if.engine             mem,
    input  logic [BUS_DATA_W-1:0] ctrl_word,
    input  logic [BUS_DATA_W-1:0] enable_word,
    input  logic [BUS_DATA_W-1:0] const_word,
    output logic                  done
);

    logic                  enable_q;
    logic                  start_edge;
    logic                  busy;
    logic                  masked_q;
    logic [COEFF_W-1:0]    const_q;
    logic                  rd_en_q;
    logic [ROW_ADDR_W-1:0] rd_addr_q;
    logic                  wr_en_q;
    logic [ROW_ADDR_W-1:0] wr_addr_q;
    logic [ROW_ADDR_W-1:0] last_row;

    // One modular add, inputs below q so one subtraction is enough
    function automatic logic [COEFF_W-1:0] add_mod(
        input logic [COEFF_W-1:0] a,
        input logic [COEFF_W-1:0] b
    );
        logic [COEFF_W:0] sum;
        sum = {1'b0, a} + {1'b0, b};
        if (sum >= (COEFF_W+1)'(NTT_Q)) begin
            sum = sum - (COEFF_W+1)'(NTT_Q);
        end
        return sum[COEFF_W-1:0];
    endfunction

    assign start_edge = enable_word[ENABLE_START_BIT] & ~enable_q;
    assign last_row   = masked_q ? ROW_ADDR_W'(ROWS_MASKED - 1)
                                 : ROW_ADDR_W'(ROWS_PLAIN - 1);

    assign mem.rd_en   = rd_en_q;
    assign mem.rd_addr = rd_addr_q;
    assign mem.wr_en   = wr_en_q;
    assign mem.wr_addr = wr_addr_q;
    assign mem.masked  = masked_q;

    // ========================================
    // Row sequencing
    // ========================================
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            enable_q  <= 1'b0;
            busy      <= 1'b0;
            masked_q  <= 1'b0;
            const_q   <= '0;
            rd_en_q   <= 1'b0;
            rd_addr_q <= '0;
            wr_en_q   <= 1'b0;
            wr_addr_q <= '0;
            done      <= 1'b0;
        end else if (zeroize) begin
            enable_q  <= 1'b0;
            busy      <= 1'b0;
            masked_q  <= 1'b0;
            const_q   <= '0;
            rd_en_q   <= 1'b0;
            rd_addr_q <= '0;
            wr_en_q   <= 1'b0;
            wr_addr_q <= '0;
            done      <= 1'b0;
        end else begin
            enable_q <= enable_word[ENABLE_START_BIT];

            // The write trails its read by the memory read latency
            wr_en_q   <= rd_en_q;
            wr_addr_q <= rd_addr_q;

            if (start_edge && !busy) begin
                // Mode and constant stay fixed for the whole run
                busy      <= 1'b1;
                done      <= 1'b0;
                masked_q  <= ctrl_word[CTRL_MASKED_BIT];
                const_q   <= const_word[COEFF_W-1:0];
                rd_en_q   <= 1'b1;
                rd_addr_q <= '0;
            end else if (rd_en_q) begin
                if (rd_addr_q == last_row) begin
                    rd_en_q <= 1'b0;
                end else begin
                    rd_addr_q <= rd_addr_q + 1'b1;
                end
            end

            // Done follows the cycle of the last row write
            if (busy && wr_en_q && (wr_addr_q == last_row)) begin
                busy <= 1'b0;
                done <= 1'b1;
            end
        end
    end

    // ========================================
    // Lane arithmetic
    // ========================================
    always_comb begin
        mem.wr_data = '0;
        for (int i = 0; i < NUM_LANES; i++) begin
            if (masked_q) begin
                // Shifting share 0 alone shifts the masked value
                mem.wr_data[i][COEFF_W-1:0]      = add_mod(mem.rd_data[i][COEFF_W-1:0], const_q);
                mem.wr_data[i][LANE_W-1:COEFF_W] = mem.rd_data[i][LANE_W-1:COEFF_W];
            end else if (i < PLAIN_LANES) begin
                mem.wr_data[i][COEFF_W-1:0]      = add_mod(mem.rd_data[i][COEFF_W-1:0], const_q);
            end
        end
    end

endmodule

//--- source/ntt_wrapper.sv
/*
  Top level of the coefficient subsystem with a plain 64-bit bus.
  Bus reads return data on the cycle after bus_en.
  ntt_done stays high from the end of a run to the next start edge.
*/

`timescale 1ns/100ps

module ntt_wrapper
    import ntt_mem_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset_n,
    input  logic                  zeroize,
    input  logic                  bus_en,
    input  logic                  bus_we,
    input  logic [MEM_ADDR_W-1:0] bus_addr,
    input  logic [BUS_DATA_W-1:0] bus_wdata,
    output logic [BUS_DATA_W-1:0] bus_rdata,
    output logic                  ntt_done
);

    // Register words from the memory to the engine
    logic [BUS_DATA_W-1:0] ctrl_word;
    logic [BUS_DATA_W-1:0] enable_word;
    logic [BUS_DATA_W-1:0] const_word;

    // Row traffic between engine and memory
    ntt_mem_if i_mem_if ();

    ntt_special_mem i_ntt_special_mem (
        .clk         (clk),
        .reset_n     (reset_n),
        .zeroize     (zeroize),
        .bus_en      (bus_en),
        .bus_we      (bus_we),
        .bus_addr    (bus_addr),
        .bus_wdata   (bus_wdata),
        .bus_rdata   (bus_rdata),
        .mem         (i_mem_if.memory),
        .done        (ntt_done),
        .ctrl_word   (ctrl_word),
        .enable_word (enable_word),
        .const_word  (const_word)
    );

    ntt_const_adder i_ntt_const_adder (
        .clk         (clk),
        .reset_n     (reset_n),
        .zeroize     (zeroize),
        .mem         (i_mem_if.engine),
        .ctrl_word   (ctrl_word),
        .enable_word (enable_word),
        .const_word  (const_word),
        .done        (ntt_done)
    );

endmodule

//--- dv/ntt_wrapper_chk.sv
/*
  Concurrent checks on the row sequencing of the constant-add engine.
  Bound into every ntt_const_adder instance through its internal registers.
  The checks assume zeroize only arrives while the engine is idle.
*/

`timescale 1ns/100ps

module ntt_wrapper_chk
    import ntt_mem_pkg::*;
    import ntt_ctrl_pkg::*;
(
    input logic                  clk,
    input logic                  reset_n,
    input logic                  zeroize,
    input logic                  rd_en,
    input logic [ROW_ADDR_W-1:0] rd_addr,
    input logic                  wr_en,
    input logic [ROW_ADDR_W-1:0] wr_addr,
    input logic                  masked,
    input logic                  done
);

    // Number of failed assertions, read by the testbench at the end
    int fail_count = 0;

    // Rows in a run for the mode that is latched now
    logic [ROW_ADDR_W:0] row_count;

    assign row_count = masked ? (ROW_ADDR_W+1)'(ROWS_MASKED) : (ROW_ADDR_W+1)'(ROWS_PLAIN);

    // ========================================
    // Read to write pipeline
    // ========================================
    // Every read is written back one cycle later at the same row
    write_follows_read: assert property (@(posedge clk) disable iff (!reset_n || zeroize)
        rd_en |=> (wr_en && (wr_addr == $past(rd_addr))))
    else begin
        $error("row write did not follow the read of the previous cycle");
        fail_count++;
    end

    // No write appears without a read one cycle before
    no_stray_write: assert property (@(posedge clk) disable iff (!reset_n || zeroize)
        !rd_en |=> !wr_en)
    else begin
        $error("row write without a read in the previous cycle");
        fail_count++;
    end

    // ========================================
    // Address range and completion
    // ========================================
    row_in_range: assert property (@(posedge clk) disable iff (!reset_n || zeroize)
        rd_en |-> ((ROW_ADDR_W+1)'(rd_addr) < row_count))
    else begin
        $error("row read address beyond the row count of the mode");
        fail_count++;
    end

    // Done only rises once the pipeline has drained
    done_when_idle: assert property (@(posedge clk) disable iff (!reset_n || zeroize)
        $rose(done) |-> (!rd_en && !wr_en))
    else begin
        $error("done rose while a row read or write was active");
        fail_count++;
    end

endmodule

bind ntt_const_adder ntt_wrapper_chk i_ntt_wrapper_chk (
    .clk     (clk),
    .reset_n (reset_n),
    .zeroize (zeroize),
    .rd_en   (rd_en_q),
    .rd_addr (rd_addr_q),
    .wr_en   (wr_en_q),
    .wr_addr (wr_addr_q),
    .masked  (masked_q),
    .done    (done)
);

//--- dv/tb_ntt_wrapper.sv
/*
  Table-driven testbench for the coefficient subsystem.
  Each case loads random words below q, runs the engine and compares
  every word with a model kept in testbench arrays.
  Inputs change 1 ns after the rising edge, outputs are sampled there too.
*/

`timescale 1ns/100ps

module tb_ntt_wrapper
    import ntt_mem_pkg::*;
    import ntt_ctrl_pkg::*;
();

    localparam int NUM_CASES    = 6;
    localparam int DONE_TIMEOUT = 100;

    typedef struct packed {
        logic               masked;
        logic [COEFF_W-1:0] constant;
        logic               clear_after;
    } test_case_t;

    logic                  clk;
    logic                  reset_n;
    logic                  zeroize;
    logic                  bus_en;
    logic                  bus_we;
    logic [MEM_ADDR_W-1:0] bus_addr;
    logic [BUS_DATA_W-1:0] bus_wdata;
    logic [BUS_DATA_W-1:0] bus_rdata;
    logic                  ntt_done;

    // Expected content of every memory word
    logic [BUS_DATA_W-1:0] model [MEM_DEPTH];
    int                    value_errors = 0;
    int                    timeout_errors = 0;

    // Mode, constant and zeroize flag, constants near q stress the wrap
    test_case_t cases [NUM_CASES] = '{
        '{1'b0, 24'd0,       1'b0},
        '{1'b0, 24'd8380416, 1'b0},
        '{1'b1, 24'd8380415, 1'b0},
        '{1'b1, 24'd1,       1'b1},
        '{1'b0, 24'd8379999, 1'b0},
        '{1'b1, 24'd4190208, 1'b1}
    };

    ntt_wrapper i_ntt_wrapper (
        .clk       (clk),
        .reset_n   (reset_n),
        .zeroize   (zeroize),
        .bus_en    (bus_en),
        .bus_we    (bus_we),
        .bus_addr  (bus_addr),
        .bus_wdata (bus_wdata),
        .bus_rdata (bus_rdata),
        .ntt_done  (ntt_done)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Reference modular add taken straight from the definition of q
    function automatic logic [COEFF_W-1:0] mod_add(input logic [COEFF_W-1:0] a,
                                                   input logic [COEFF_W-1:0] b);
        int unsigned sum;
        sum = 32'(a) + 32'(b);
        return COEFF_W'(sum % NTT_Q);
    endfunction

    function automatic logic [COEFF_W-1:0] random_coeff();
        return COEFF_W'($urandom % NTT_Q);
    endfunction

    // ========================================
    // Bus tasks
    // ========================================
    task automatic bus_write(input logic [MEM_ADDR_W-1:0] addr,
                             input logic [BUS_DATA_W-1:0] data);
        bus_en    = 1'b1;
        bus_we    = 1'b1;
        bus_addr  = addr;
        bus_wdata = data;
        @(posedge clk);
        #1;
        bus_en = 1'b0;
        bus_we = 1'b0;
    endtask

    task automatic bus_read(input logic [MEM_ADDR_W-1:0] addr,
                            output logic [BUS_DATA_W-1:0] data);
        bus_en   = 1'b1;
        bus_we   = 1'b0;
        bus_addr = addr;
        @(posedge clk);
        #1;
        bus_en = 1'b0;
        data   = bus_rdata;
    endtask

    task automatic compare_memory();
        logic [BUS_DATA_W-1:0] got;
        for (int i = 0; i < MEM_DEPTH; i++) begin
            bus_read(MEM_ADDR_W'(i), got);
            if (got !== model[i]) begin
                $display("[FAIL] %0t: word %0d read %h, expected %h", $time, i, got, model[i]);
                value_errors++;
            end
        end
        // The cycle after an idle bus cycle returns zero
        @(posedge clk);
        #1;
        if (bus_rdata !== '0) begin
            $display("[FAIL] %0t: bus_rdata %h after an idle cycle", $time, bus_rdata);
            value_errors++;
        end
    endtask

    task automatic check_done(input logic expected);
        if (ntt_done !== expected) begin
            $display("[FAIL] %0t: ntt_done is %b, expected %b", $time, ntt_done, expected);
            value_errors++;
        end
    endtask

    // Poll the status word until bit 0 is set or the limit runs out
    task automatic wait_done();
        logic [BUS_DATA_W-1:0] status;
        int                    cycles;
        status = '0;
        cycles = 0;
        while (status[0] !== 1'b1 && cycles < DONE_TIMEOUT) begin
            bus_read(STATUS_REG, status);
            cycles++;
        end
        if (status[0] !== 1'b1) begin
            $display("The run did not finish within %0d cycles", DONE_TIMEOUT);
            timeout_errors++;
        end
    endtask

    // ========================================
    // Main sequence
    // ========================================
    initial begin
        test_case_t            tc;
        coeff_word_u           word;
        coeff_word_u           expected;
        logic [BUS_DATA_W-1:0] data;
        int                    assert_errors;

        void'($urandom(32'h3152_4d6d));
        reset_n   = 1'b0;
        zeroize   = 1'b0;
        bus_en    = 1'b0;
        bus_we    = 1'b0;
        bus_addr  = '0;
        bus_wdata = '0;
        for (int i = 0; i < MEM_DEPTH; i++) begin
            model[i] = '0;
        end
        repeat (2) @(posedge clk);
        #1;
        reset_n = 1'b1;

        // Everything reads zero and done is low before the first start edge
        check_done(1'b0);
        compare_memory();

        for (int c = 0; c < NUM_CASES; c++) begin
            tc = cases[c];
            for (int w = 0; w < 64; w++) begin
                word = '0;
                if (tc.masked) begin
                    word.masked.share1 = random_coeff();
                    word.masked.share0 = random_coeff();
                end else begin
                    word.plain.coeff = random_coeff();
                end
                bus_write(MEM_ADDR_W'(w), word);
                model[w] = word;
            end
            // Scratch words hold arbitrary data the engine must not touch
            for (int w = 64; w < CTRL_REG; w++) begin
                data = {$urandom, $urandom};
                bus_write(MEM_ADDR_W'(w), data);
                model[w] = data;
            end
            bus_write(CONST_REG, BUS_DATA_W'(tc.constant));
            bus_write(CTRL_REG, BUS_DATA_W'(tc.masked));
            bus_write(ENABLE_REG, '0);
            bus_write(ENABLE_REG, 64'd1);
            model[CONST_REG]  = BUS_DATA_W'(tc.constant);
            model[CTRL_REG]   = BUS_DATA_W'(tc.masked);
            model[ENABLE_REG] = 64'd1;

            // The start edge clears done from the previous run
            @(posedge clk);
            #1;
            check_done(1'b0);
            // The status word copies done one cycle later
            @(posedge clk);
            #1;
            bus_read(STATUS_REG, data);
            if (data[0] !== 1'b0) begin
                $display("[FAIL] %0t: status bit 0 still set after the start edge", $time);
                value_errors++;
            end
            wait_done();
            check_done(1'b1);

            for (int w = 0; w < 64; w++) begin
                word     = coeff_word_u'(model[w]);
                expected = '0;
                if (tc.masked) begin
                    expected.masked.share1 = word.masked.share1;
                    expected.masked.share0 = mod_add(word.masked.share0, tc.constant);
                end else begin
                    expected.plain.coeff = mod_add(word.plain.coeff, tc.constant);
                end
                model[w] = expected;
            end
            model[STATUS_REG] = 64'd1;
            compare_memory();

            if (tc.clear_after) begin
                zeroize = 1'b1;
                @(posedge clk);
                #1;
                zeroize = 1'b0;
                for (int i = 0; i < MEM_DEPTH; i++) begin
                    model[i] = '0;
                end
                check_done(1'b0);
                compare_memory();
            end
        end

        assert_errors = i_ntt_wrapper.i_ntt_const_adder.i_ntt_wrapper_chk.fail_count;
        $display("Errors: %0d value, %0d timeout, %0d assertion",
                 value_errors, timeout_errors, assert_errors);
        if (value_errors + timeout_errors + assert_errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

//--- verilog.f
source/ntt_mem_pkg.sv
source/ntt_ctrl_pkg.sv
source/ntt_mem_if.sv
source/ntt_special_mem.sv
source/ntt_const_adder.sv
source/ntt_wrapper.sv
dv/ntt_wrapper_chk.sv
dv/tb_ntt_wrapper.sv

//--- Makefile
SIM       = verilator
TOP       = tb_ntt_wrapper
FILELIST  = verilog.f
SIM_FLAGS = --binary --timing --assert -Wno-fatal --top-module $(TOP)
RUN_FLAGS = +verilator+error+limit+1000
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: simulate clean

simulate:
	$(SIM) $(SIM_FLAGS) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) $(RUN_FLAGS) | tee $(LOG)
	grep -q "All tests passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
